//--- all.f
+incdir+.
mldsa_masked_pkg.sv
masked_add_sub.sv
masked_mult.sv
share_delay.sv
masked_gs_butterfly.sv
rnd_lfsr.sv
ntt_apb_regs.sv
ntt_masked_bf_top.sv
tb_ntt_masked_bf.sv

//--- tb_ntt_masked_bf.sv
// masked butterfly testbench
`include "ntt_config.svh"

module tb_ntt_masked_bf
    import mldsa_masked_pkg::*;
();

    localparam int unsigned Q = `NTT_Q;
    localparam int DRV = 10;
    localparam int POLL_MAX = 20;

    logic      clk;
    logic      reset_n;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;

    apb_addr_t   zero_regs [13];

    ntt_masked_bf_top UUT (
        .clk(clk), .reset_n(reset_n),
        .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
        .paddr_i(paddr), .pwdata_i(pwdata), .prdata_o(prdata),
        .pready_o(pready), .pslverr_o(pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_on_error(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        $display("Result: FAILED");
        $fatal(1, "check mismatch");
    endtask

    // unmasked reference for (u+v) mod q and ((u-v)*w) mod q
    function automatic void bf_ref(input int unsigned u, input int unsigned v,
                                   input int unsigned w, output coeff_t su, output coeff_t pv);
        longint unsigned diff;
        longint unsigned prod;
        su = coeff_t'((u + v) % Q);
        diff = u;
        diff = (diff + Q - v) % Q;
        prod = (diff * w) % Q;
        pv = coeff_t'(prod);
    endfunction

    function automatic void split_shares(input int unsigned x, output coeff_t s0,
                                         output coeff_t s1);
        int unsigned r;
        r = $urandom % Q;
        s0 = coeff_t'(r);
        s1 = coeff_t'((x + Q - r) % Q);
    endfunction

    task automatic check_coeff(input string what, input coeff_t s0, input coeff_t s1,
                               input coeff_t exp);
        int unsigned sum;
        if (s0 >= Q || s1 >= Q)
            stop_on_error($sformatf("%s: share out of range %0d %0d", what, s0, s1));
        sum = s0;
        sum = (sum + s1) % Q;
        if (sum != exp)
            stop_on_error($sformatf("%s: got %0d expected %0d", what, sum, exp));
    endtask

    task automatic check_apb_data(input string what, input apb_data_t got, input apb_data_t exp);
        if (got !== exp)
            stop_on_error($sformatf("%s: got 0x%08h expected 0x%08h", what, got, exp));
    endtask

    task automatic check_err(input string what, input logic got, input logic exp);
        if (got !== exp)
            stop_on_error($sformatf("%s: pslverr %b expected %b", what, got, exp));
    endtask

    // setup and access phase with sampling at the falling edge
    task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b1;
        paddr = addr;
        pwdata = data;
        @(posedge clk);
        #DRV;
        penable = 1'b1;
        @(negedge clk);
        if (pready !== 1'b1)
            stop_on_error("pready low in access phase");
        err = pslverr;
        @(posedge clk);
        #DRV;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = addr;
        @(posedge clk);
        #DRV;
        penable = 1'b1;
        @(negedge clk);
        if (pready !== 1'b1)
            stop_on_error("pready low in access phase");
        data = prdata;
        err = pslverr;
        @(posedge clk);
        #DRV;
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_reg(input apb_addr_t addr, input apb_data_t data);
        logic err;
        apb_write(addr, data, err);
        check_err($sformatf("write 0x%02h", addr), err, 1'b0);
    endtask

    task automatic read_check(input apb_addr_t addr, input apb_data_t exp, input string what);
        apb_data_t rd;
        logic err;
        apb_read(addr, rd, err);
        check_err(what, err, 1'b0);
        check_apb_data(what, rd, exp);
    endtask

    task automatic wait_done();
        apb_data_t status;
        logic err;
        int polls;
        polls = 0;
        status = '0;
        while (status[1] !== 1'b1) begin
            if (polls == POLL_MAX) begin
                $display("timeout: STATUS done bit not set after %0d polls", POLL_MAX);
                $display("Result: FAILED");
                $fatal(1, "timeout");
            end
            apb_read(`REG_STATUS, status, err);
            polls++;
        end
        // busy must have dropped with done
        check_apb_data("STATUS at done", status, 32'h2);
    endtask

    task automatic load_operands(input int unsigned u, input int unsigned v,
                                 input int unsigned w);
        coeff_t s0, s1;
        split_shares(u, s0, s1);
        write_reg(`REG_OPU0, apb_data_t'(s0));
        write_reg(`REG_OPU1, apb_data_t'(s1));
        split_shares(v, s0, s1);
        write_reg(`REG_OPV0, apb_data_t'(s0));
        write_reg(`REG_OPV1, apb_data_t'(s1));
        split_shares(w, s0, s1);
        write_reg(`REG_OPW0, apb_data_t'(s0));
        write_reg(`REG_OPW1, apb_data_t'(s1));
    endtask

    task automatic read_results(output coeff_t su0, output coeff_t su1,
                                output coeff_t pv0, output coeff_t pv1);
        apb_data_t rd;
        logic err;
        apb_read(`REG_RESU0, rd, err);
        check_err("read RESU0", err, 1'b0);
        su0 = coeff_t'(rd);
        apb_read(`REG_RESU1, rd, err);
        check_err("read RESU1", err, 1'b0);
        su1 = coeff_t'(rd);
        apb_read(`REG_RESV0, rd, err);
        check_err("read RESV0", err, 1'b0);
        pv0 = coeff_t'(rd);
        apb_read(`REG_RESV1, rd, err);
        check_err("read RESV1", err, 1'b0);
        pv1 = coeff_t'(rd);
    endtask

    task automatic run_op(input int unsigned u, input int unsigned v, input int unsigned w,
                          output coeff_t su0, output coeff_t su1,
                          output coeff_t pv0, output coeff_t pv1);
        load_operands(u, v, w);
        write_reg(`REG_CTRL, 32'h1);
        wait_done();
        read_results(su0, su1, pv0, pv1);
    endtask

    task automatic check_op(input int unsigned u, input int unsigned v, input int unsigned w,
                            input coeff_t su0, input coeff_t su1,
                            input coeff_t pv0, input coeff_t pv1, input string tag);
        coeff_t exp_su, exp_pv;
        bf_ref(u, v, w, exp_su, exp_pv);
        check_coeff({tag, " sum"}, su0, su1, exp_su);
        check_coeff({tag, " product"}, pv0, pv1, exp_pv);
    endtask

    task automatic run_and_check(input int unsigned u, input int unsigned v,
                                 input int unsigned w, input string tag);
        coeff_t su0, su1, pv0, pv1;
        run_op(u, v, w, su0, su1, pv0, pv1);
        check_op(u, v, w, su0, su1, pv0, pv1, tag);
    endtask

    initial begin
        apb_data_t rd;
        logic err;
        int unsigned u, v, w;
        coeff_t a_su0, a_su1, a_pv0, a_pv1;
        coeff_t b_su0, b_su1, b_pv0, b_pv1;
        reset_n = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        void'($urandom(75));
        zero_regs = '{`REG_CTRL, `REG_STATUS, `REG_SEED, `REG_OPU0, `REG_OPU1,
                      `REG_OPV0, `REG_OPV1, `REG_OPW0, `REG_OPW1,
                      `REG_RESU0, `REG_RESU1, `REG_RESV0, `REG_RESV1};
        repeat (5) @(posedge clk);
        #DRV;
        reset_n = 1'b1;
        @(posedge clk);
        #DRV;

        // everything reads zero out of reset
        for (int i = 0; i < 13; i++)
            read_check(zero_regs[i], '0, $sformatf("reset value at 0x%02h", zero_regs[i]));
        apb_read(8'h40, rd, err);
        check_err("unmapped read 0x40", err, 1'b1);
        apb_read(8'h0C, rd, err);
        check_err("unmapped read 0x0C", err, 1'b1);

        // directed and edge cases
        run_and_check(1234567, 7654321, 1753, "directed");
        run_and_check(4000000, 4000000, 99999, "u equals v");
        run_and_check(5555555, 0, 2222222, "v zero");
        run_and_check(3141592, 2718281, 0, "w zero");
        run_and_check(Q - 1, 12345, 6789012, "u max");
        run_and_check(777, Q - 1, 4242424, "v max");
        run_and_check(8000000, 100, Q - 1, "w max");

        for (int n = 0; n < 200; n++) begin
            u = $urandom % Q;
            v = $urandom % Q;
            w = $urandom % Q;
            run_and_check(u, v, w, $sformatf("random %0d", n));
        end

        // same values under new shares and a new seed
        write_reg(`REG_SEED, 32'h1234_5678);
        read_check(`REG_SEED, 32'h1234_5678, "SEED readback");
        run_op(100000, 20000, 333, a_su0, a_su1, a_pv0, a_pv1);
        check_op(100000, 20000, 333, a_su0, a_su1, a_pv0, a_pv1, "seed a");
        write_reg(`REG_SEED, 32'h9E37_79B9);
        run_op(100000, 20000, 333, b_su0, b_su1, b_pv0, b_pv1);
        check_op(100000, 20000, 333, b_su0, b_su1, b_pv0, b_pv1, "seed b");
        if (a_su0 == b_su0 && a_su1 == b_su1)
            stop_on_error("sum shares repeat under a new split and seed");
        if (a_pv0 == b_pv0 && a_pv1 == b_pv1)
            stop_on_error("product shares repeat under a new split and seed");

        // second start lands while the first is in flight
        load_operands(2000000, 6000000, 54321);
        write_reg(`REG_CTRL, 32'h1);
        write_reg(`REG_OPU0, 32'h0005_A5A5);
        write_reg(`REG_CTRL, 32'h1);
        wait_done();
        read_results(a_su0, a_su1, a_pv0, a_pv1);
        check_op(2000000, 6000000, 54321, a_su0, a_su1, a_pv0, a_pv1, "busy start");
        apb_write(`REG_RESU0, 32'h1, err);
        check_err("write to RESU0", err, 1'b1);
        apb_write(`REG_STATUS, 32'h3, err);
        check_err("write to STATUS", err, 1'b1);
        read_check(`REG_RESU0, apb_data_t'(a_su0), "RESU0 after rejected write");

        // zeroize wipes results and done
        run_and_check(7000000, 3000000, 1111111, "before zeroize");
        write_reg(`REG_CTRL, 32'h2);
        read_check(`REG_STATUS, '0, "STATUS after zeroize");
        read_check(`REG_RESU0, '0, "RESU0 after zeroize");
        read_check(`REG_RESU1, '0, "RESU1 after zeroize");
        read_check(`REG_RESV0, '0, "RESV0 after zeroize");
        read_check(`REG_RESV1, '0, "RESV1 after zeroize");
        run_and_check(42, 8379999, 2500000, "after zeroize");

        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- ntt_masked_bf_top.sv
// masked butterfly APB subsystem
module ntt_masked_bf_top
    import mldsa_masked_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  logic      psel_i,
    input  logic      penable_i,
    input  logic      pwrite_i,
    input  apb_addr_t paddr_i,
    input  apb_data_t pwdata_i,
    output apb_data_t prdata_o,
    output logic      pready_o,
    output logic      pslverr_o
);

    logic      seed_load;
    apb_data_t seed;
    logic      bf_valid, bf_zeroize, res_valid;
    coeff_t    u0, u1, v0, v1, w0, w1;
    coeff_t    su0, su1, pv0, pv1;
    rnd_t      rnd_add, rnd_sub, rnd_mul;

    ntt_apb_regs u_regs (
        .clk(clk), .reset_n(reset_n),
        .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
        .paddr_i(paddr_i), .pwdata_i(pwdata_i), .prdata_o(prdata_o),
        .pready_o(pready_o), .pslverr_o(pslverr_o),
        .seed_load_o(seed_load), .seed_o(seed),
        .bf_valid_o(bf_valid), .bf_zeroize_o(bf_zeroize),
        .u0_o(u0), .u1_o(u1), .v0_o(v0), .v1_o(v1), .w0_o(w0), .w1_o(w1),
        .res_valid_i(res_valid), .su0_i(su0), .su1_i(su1), .pv0_i(pv0), .pv1_i(pv1)
    );

    rnd_lfsr u_lfsr (
        .clk(clk), .reset_n(reset_n), .load_i(seed_load), .seed_i(seed),
        .rnd_add_o(rnd_add), .rnd_sub_o(rnd_sub), .rnd_mul_o(rnd_mul)
    );

    masked_gs_butterfly u_bf (
        .clk(clk), .reset_n(reset_n), .zeroize_i(bf_zeroize), .valid_i(bf_valid),
        .u0_i(u0), .u1_i(u1), .v0_i(v0), .v1_i(v1), .w0_i(w0), .w1_i(w1),
        .rnd_add_i(rnd_add), .rnd_sub_i(rnd_sub), .rnd_mul_i(rnd_mul),
        .valid_o(res_valid), .su0_o(su0), .su1_o(su1), .pv0_o(pv0), .pv1_o(pv1)
    );

endmodule

//--- ntt_apb_regs.sv
// APB registers and butterfly control
`include "ntt_config.svh"

module ntt_apb_regs
    import mldsa_masked_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  logic      psel_i,
    input  logic      penable_i,
    input  logic      pwrite_i,
    input  apb_addr_t paddr_i,
    input  apb_data_t pwdata_i,
    output apb_data_t prdata_o,
    output logic      pready_o,
    output logic      pslverr_o,
    output logic      seed_load_o,
    output apb_data_t seed_o,
    output logic      bf_valid_o,
    output logic      bf_zeroize_o,
    output coeff_t    u0_o,
    output coeff_t    u1_o,
    output coeff_t    v0_o,
    output coeff_t    v1_o,
    output coeff_t    w0_o,
    output coeff_t    w1_o,
    input  logic      res_valid_i,
    input  coeff_t    su0_i,
    input  coeff_t    su1_i,
    input  coeff_t    pv0_i,
    input  coeff_t    pv1_i
);

    localparam int CNT_W = $clog2(`BF_LAT + 1);

    ctrl_state_t state;
    logic [CNT_W-1:0] wait_cnt;
    coeff_t res_u0, res_u1, res_v0, res_v1;
    logic access;
    logic mapped;
    logic read_only;
    logic wr_ok;
    logic start_wr;
    logic zero_wr;

    // address decode
    always_comb begin
        mapped    = 1'b1;
        read_only = 1'b0;
        prdata_o  = '0;
        case (paddr_i)
            `REG_CTRL:   prdata_o = '0;
            `REG_STATUS: begin
                prdata_o  = {30'b0, state == DONE, state == RUN};
                read_only = 1'b1;
            end
            `REG_SEED:   prdata_o = seed_o;
            `REG_OPU0:   prdata_o = apb_data_t'(u0_o);
            `REG_OPU1:   prdata_o = apb_data_t'(u1_o);
            `REG_OPV0:   prdata_o = apb_data_t'(v0_o);
            `REG_OPV1:   prdata_o = apb_data_t'(v1_o);
            `REG_OPW0:   prdata_o = apb_data_t'(w0_o);
            `REG_OPW1:   prdata_o = apb_data_t'(w1_o);
            `REG_RESU0, `REG_RESU1, `REG_RESV0, `REG_RESV1: begin
                read_only = 1'b1;
                case (paddr_i)
                    `REG_RESU0: prdata_o = apb_data_t'(res_u0);
                    `REG_RESU1: prdata_o = apb_data_t'(res_u1);
                    `REG_RESV0: prdata_o = apb_data_t'(res_v0);
                    default:    prdata_o = apb_data_t'(res_v1);
                endcase
            end
            default:     mapped = 1'b0;
        endcase
    end

    // no wait states
    assign pready_o  = 1'b1;
    assign access    = psel_i & penable_i;
    assign pslverr_o = access & (~mapped | (pwrite_i & read_only));
    assign wr_ok     = access & pwrite_i & mapped & ~read_only;
    assign start_wr  = wr_ok & (paddr_i == `REG_CTRL) & pwdata_i[0];
    assign zero_wr   = wr_ok & (paddr_i == `REG_CTRL) & pwdata_i[1];

    // operand and seed registers, kept to share width
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            seed_load_o <= 1'b0;
            seed_o      <= '0;
            u0_o        <= '0;
            u1_o        <= '0;
            v0_o        <= '0;
            v1_o        <= '0;
            w0_o        <= '0;
            w1_o        <= '0;
        end else begin
            seed_load_o <= wr_ok & (paddr_i == `REG_SEED);
            if (wr_ok) begin
                case (paddr_i)
                    `REG_SEED: seed_o <= pwdata_i;
                    `REG_OPU0: u0_o   <= pwdata_i[`COEFF_W-1:0];
                    `REG_OPU1: u1_o   <= pwdata_i[`COEFF_W-1:0];
                    `REG_OPV0: v0_o   <= pwdata_i[`COEFF_W-1:0];
                    `REG_OPV1: v1_o   <= pwdata_i[`COEFF_W-1:0];
                    `REG_OPW0: w0_o   <= pwdata_i[`COEFF_W-1:0];
                    `REG_OPW1: w1_o   <= pwdata_i[`COEFF_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    // control FSM, zeroize takes priority over start
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state        <= IDLE;
            wait_cnt     <= '0;
            bf_valid_o   <= 1'b0;
            bf_zeroize_o <= 1'b0;
        end else begin
            bf_valid_o   <= 1'b0;
            bf_zeroize_o <= zero_wr;
            if (zero_wr) begin
                state <= IDLE;
            end else begin
                case (state)
                    IDLE, DONE: begin
                        if (start_wr) begin
                            state      <= RUN;
                            bf_valid_o <= 1'b1;
                            wait_cnt   <= '0;
                        end
                    end
                    RUN: begin
                        if (res_valid_i) begin
                            state <= DONE;
                        end else if (wait_cnt == CNT_W'(`BF_LAT)) begin
                            // result never came back, give up
                            state <= IDLE;
                        end else begin
                            wait_cnt <= wait_cnt + 1'b1;
                        end
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    // result capture
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            res_u0 <= '0;
            res_u1 <= '0;
            res_v0 <= '0;
            res_v1 <= '0;
        end else if (zero_wr) begin
            res_u0 <= '0;
            res_u1 <= '0;
            res_v0 <= '0;
            res_v1 <= '0;
        end else if (state == RUN && res_valid_i) begin
            res_u0 <= su0_i;
            res_u1 <= su1_i;
            res_v0 <= pv0_i;
            res_v1 <= pv1_i;
        end
    end

endmodule

//--- rnd_lfsr.sv
// refresh randomness LFSR
`include "ntt_config.svh"

module rnd_lfsr
    import mldsa_masked_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  logic      load_i,
    input  apb_data_t seed_i,
    output rnd_t      rnd_add_o,
    output rnd_t      rnd_sub_o,
    output rnd_t      rnd_mul_o
);

    // x^32 + x^30 + x^26 + x^25 + 1, right shifting Galois form
    localparam apb_data_t POLY = 32'hA300_0000;
    localparam apb_data_t SEED_DEFAULT = 32'h6A09_E667;

    apb_data_t state;

    function automatic rnd_t reduce_q(input logic [`COEFF_W-1:0] x);
        return (x >= `NTT_Q) ? rnd_t'(x - `NTT_Q) : x;
    endfunction

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= SEED_DEFAULT;
        end else if (load_i) begin
            // all-zero state would lock up
            state <= (seed_i == '0) ? SEED_DEFAULT : seed_i;
        end else begin
            state <= {1'b0, state[31:1]} ^ (state[0] ? POLY : '0);
        end
    end

    // overlapping windows, each pulled below q
    assign rnd_add_o = reduce_q(state[22:0]);
    assign rnd_sub_o = reduce_q(state[27:5]);
    assign rnd_mul_o = reduce_q(state[31:9]);

endmodule

//--- masked_gs_butterfly.sv
// masked Gentleman-Sande butterfly
`include "ntt_config.svh"

module masked_gs_butterfly
    import mldsa_masked_pkg::*;
(
    input  logic   clk,
    input  logic   reset_n,
    input  logic   zeroize_i,
    input  logic   valid_i,
    input  coeff_t u0_i,
    input  coeff_t u1_i,
    input  coeff_t v0_i,
    input  coeff_t v1_i,
    input  coeff_t w0_i,
    input  coeff_t w1_i,
    input  rnd_t   rnd_add_i,
    input  rnd_t   rnd_sub_i,
    input  rnd_t   rnd_mul_i,
    output logic   valid_o,
    output coeff_t su0_o,
    output coeff_t su1_o,
    output coeff_t pv0_o,
    output coeff_t pv1_o
);

    coeff_t sum0, sum1;
    coeff_t dif0, dif1;
    coeff_t wd0, wd1;
    coeff_t sumd0, sumd1;
    coeff_t prd0, prd1;
    logic [`BF_LAT-1:0] valid_sr;

    // u + v
    masked_add_sub #(.SUB(1'b0)) u_add (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i),
        .a0_i(u0_i), .a1_i(u1_i), .b0_i(v0_i), .b1_i(v1_i),
        .rnd_i(rnd_add_i), .r0_o(sum0), .r1_o(sum1)
    );

    // u - v
    masked_add_sub #(.SUB(1'b1)) u_sub (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i),
        .a0_i(u0_i), .a1_i(u1_i), .b0_i(v0_i), .b1_i(v1_i),
        .rnd_i(rnd_sub_i), .r0_o(dif0), .r1_o(dif1)
    );

    // twiddle waits for the difference
    share_delay #(.N(`ADDSUB_LAT)) u_w_dly (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i),
        .d0_i(w0_i), .d1_i(w1_i), .q0_o(wd0), .q1_o(wd1)
    );

    masked_mult u_mult (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i),
        .a0_i(dif0), .a1_i(dif1), .w0_i(wd0), .w1_i(wd1),
        .rnd_i(rnd_mul_i), .p0_o(prd0), .p1_o(prd1)
    );

    // sum path matched to the multiplier
    share_delay #(.N(`MULT_LAT)) u_sum_dly (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i),
        .d0_i(sum0), .d1_i(sum1), .q0_o(sumd0), .q1_o(sumd1)
    );

    // halving is left to the first NTT stage
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_sr <= '0;
            su0_o    <= '0;
            su1_o    <= '0;
            pv0_o    <= '0;
            pv1_o    <= '0;
        end else if (zeroize_i) begin
            valid_sr <= '0;
            su0_o    <= '0;
            su1_o    <= '0;
            pv0_o    <= '0;
            pv1_o    <= '0;
        end else begin
            valid_sr <= {valid_sr[`BF_LAT-2:0], valid_i};
            su0_o    <= sumd0;
            su1_o    <= sumd1;
            pv0_o    <= prd0;
            pv1_o    <= prd1;
        end
    end

    assign valid_o = valid_sr[`BF_LAT-1];

endmodule

//--- share_delay.sv
// two share delay line
module share_delay
    import mldsa_masked_pkg::*;
#(
    parameter int N = 1
) (
    input  logic   clk,
    input  logic   reset_n,
    input  logic   zeroize_i,
    input  coeff_t d0_i,
    input  coeff_t d1_i,
    output coeff_t q0_o,
    output coeff_t q1_o
);

    coeff_t line0 [N];
    coeff_t line1 [N];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < N; i++) begin
                line0[i] <= '0;
                line1[i] <= '0;
            end
        end else if (zeroize_i) begin
            for (int i = 0; i < N; i++) begin
                line0[i] <= '0;
                line1[i] <= '0;
            end
        end else begin
            line0[0] <= d0_i;
            line1[0] <= d1_i;
            for (int i = 1; i < N; i++) begin
                line0[i] <= line0[i-1];
                line1[i] <= line1[i-1];
            end
        end
    end

    assign q0_o = line0[N-1];
    assign q1_o = line1[N-1];

endmodule

//--- masked_mult.sv
// three stage masked modular multiplier
`include "ntt_config.svh"

module masked_mult
    import mldsa_masked_pkg::*;
(
    input  logic   clk,
    input  logic   reset_n,
    input  logic   zeroize_i,
    input  coeff_t a0_i,
    input  coeff_t a1_i,
    input  coeff_t w0_i,
    input  coeff_t w1_i,
    input  rnd_t   rnd_i,
    output coeff_t p0_o,
    output coeff_t p1_o
);

    localparam int PROD_W = 2 * `COEFF_W;

    // stage 1 cross products
    logic [PROD_W-1:0] prod_00;
    logic [PROD_W-1:0] prod_01;
    logic [PROD_W-1:0] prod_10;
    logic [PROD_W-1:0] prod_11;
    // stage 2 reduced products
    coeff_t red_00;
    coeff_t red_01;
    coeff_t red_10;
    coeff_t red_11;
    // refresh value travelling with the data
    rnd_t rnd_s1;
    rnd_t rnd_s2;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_00 <= '0;
            prod_01 <= '0;
            prod_10 <= '0;
            prod_11 <= '0;
            red_00  <= '0;
            red_01  <= '0;
            red_10  <= '0;
            red_11  <= '0;
            rnd_s1  <= '0;
            rnd_s2  <= '0;
            p0_o    <= '0;
            p1_o    <= '0;
        end else if (zeroize_i) begin
            prod_00 <= '0;
            prod_01 <= '0;
            prod_10 <= '0;
            prod_11 <= '0;
            red_00  <= '0;
            red_01  <= '0;
            red_10  <= '0;
            red_11  <= '0;
            rnd_s1  <= '0;
            rnd_s2  <= '0;
            p0_o    <= '0;
            p1_o    <= '0;
        end else begin
            prod_00 <= a0_i * w0_i;
            prod_01 <= a0_i * w1_i;
            prod_10 <= a1_i * w0_i;
            prod_11 <= a1_i * w1_i;
            rnd_s1  <= rnd_i;

            red_00  <= coeff_t'(prod_00 % `NTT_Q);
            red_01  <= coeff_t'(prod_01 % `NTT_Q);
            red_10  <= coeff_t'(prod_10 % `NTT_Q);
            red_11  <= coeff_t'(prod_11 % `NTT_Q);
            rnd_s2  <= rnd_s1;

            // share 0 gathers the a0 terms, share 1 the a1 terms
            p0_o    <= add_mod_q(add_mod_q(red_00, red_01), rnd_s2);
            p1_o    <= sub_mod_q(add_mod_q(red_10, red_11), rnd_s2);
        end
    end

endmodule

//--- masked_add_sub.sv
// masked modular adder and subtracter
`include "ntt_config.svh"

module masked_add_sub
    import mldsa_masked_pkg::*;
#(
    parameter bit SUB = 1'b0
) (
    input  logic   clk,
    input  logic   reset_n,
    input  logic   zeroize_i,
    input  coeff_t a0_i,
    input  coeff_t a1_i,
    input  coeff_t b0_i,
    input  coeff_t b1_i,
    input  rnd_t   rnd_i,
    output coeff_t r0_o,
    output coeff_t r1_o
);

    coeff_t comb0;
    coeff_t comb1;
    coeff_t fresh0;
    coeff_t fresh1;

    // sharewise combine, no share ever meets the other
    always_comb begin
        if (SUB) begin
            comb0 = sub_mod_q(a0_i, b0_i);
            comb1 = sub_mod_q(a1_i, b1_i);
        end else begin
            comb0 = add_mod_q(a0_i, b0_i);
            comb1 = add_mod_q(a1_i, b1_i);
        end
        // remask: +r on share 0, -r on share 1
        fresh0 = add_mod_q(comb0, rnd_i);
        fresh1 = sub_mod_q(comb1, rnd_i);
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r0_o <= '0;
            r1_o <= '0;
        end else if (zeroize_i) begin
            r0_o <= '0;
            r1_o <= '0;
        end else begin
            r0_o <= fresh0;
            r1_o <= fresh1;
        end
    end

endmodule

//--- mldsa_masked_pkg.sv
// masked arithmetic types
`include "ntt_config.svh"

package mldsa_masked_pkg;

    // one arithmetic share, always kept below q
    typedef logic [`COEFF_W-1:0] coeff_t;
    // refresh randomness, reduced below q by the LFSR
    typedef logic [`COEFF_W-1:0] rnd_t;

    typedef logic [7:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    typedef enum logic [1:0] {IDLE, RUN, DONE} ctrl_state_t;

    // operands must already be below q
    function automatic coeff_t add_mod_q(input coeff_t x, input coeff_t y);
        logic [`COEFF_W:0] s;
        s = x + y;
        if (s >= `NTT_Q) s = s - `NTT_Q;
        return s[`COEFF_W-1:0];
    endfunction

    function automatic coeff_t sub_mod_q(input coeff_t x, input coeff_t y);
        logic [`COEFF_W:0] d;
        d = {1'b0, x} - {1'b0, y};
        // borrow wraps, adding q brings the low bits back into range
        if (x < y) d = d + `NTT_Q;
        return d[`COEFF_W-1:0];
    endfunction

endpackage

//--- ntt_config.svh
// masked butterfly configuration
`ifndef NTT_CONFIG_SVH
`define NTT_CONFIG_SVH

// ML-DSA modulus and share width
`define NTT_Q 23'd8380417
`define COEFF_W 23

// pipeline depths in clock cycles
`define ADDSUB_LAT 1
`define MULT_LAT 3
`define BF_LAT 5

// APB byte addresses
`define REG_CTRL 8'h00
`define REG_STATUS 8'h04
`define REG_SEED 8'h08
`define REG_OPU0 8'h10
`define REG_OPU1 8'h14
`define REG_OPV0 8'h18
`define REG_OPV1 8'h1C
`define REG_OPW0 8'h20
`define REG_OPW1 8'h24
`define REG_RESU0 8'h30
`define REG_RESU1 8'h34
`define REG_RESV0 8'h38
`define REG_RESV1 8'h3C

`endif
